// ==== rv_core.f ====
+incdir+design
+incdir+sim
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/rv_ctrl_if.sv
design/rv_decoder.sv
design/rv_execute.sv
design/rv_mem_stage.sv
design/rv_core.sv
sim/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -f rv_core.f \
  --Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error"
fi
cat "$LOG"

if grep -q "^Everything OK$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// ==== sim/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// instruction encoders
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, opc_op};
endfunction

function automatic logic [31:0] enc_i(input rv_opcode_e op, input logic [4:0] rd,
                                      input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] enc_u(input rv_opcode_e op, input logic [4:0] rd,
                                      input logic [31:0] imm);
  return {imm[31:12], rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b, input logic alt);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

`endif

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_core_tb;
  import rv_isa_pkg::*;

  `include "rv_ref_model.svh"

  localparam int MEM_WORDS = 256;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic [31:0] instr_data;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [3:0]  data_wenable;
  logic [31:0] data_rdata;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] m_mem [MEM_WORDS];  // model copy of data memory
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;
  logic [31:0] exp_pc;
  logic [3:0]  exp_wen;
  logic [31:0] exp_addr;
  logic [31:0] exp_wdata;
  logic        halted;
  logic        prog_ready;
  logic [31:0] lfsr;
  int          prog_len;
  int          out_off;
  int          pc_errors;
  int          mem_errors;
  int          misc_errors;

  rv_core uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_addr   (instr_addr),
    .instr_data   (instr_data),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_wenable (data_wenable),
    .data_rdata   (data_rdata)
  );

  assign instr_data = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[9:2]];

  always @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      if (data_wenable[k]) dmem[data_addr[9:2]][8*k +: 8] <= data_wdata[8*k +: 8];
    end
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h8020_0003;
      v = {v[30:0], lsb};
    end
    return v;
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;  // addi sign-extends the low part
    emit(enc_u(opc_lui, rd, {hi[31:12], 12'h000}));
    emit(enc_i(opc_op_imm, rd, 3'b000, rd, v[11:0]));
  endtask

  task automatic store_result(input logic [4:0] rs);
    emit(enc_s(3'b010, 5'd11, rs, 12'(out_off)));
    out_off += 4;
  endtask

  task automatic build_program();
    logic [2:0] br_f3 [6];
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    emit(enc_i(opc_op_imm, 5'd10, 3'b000, 5'd0, 12'h100));  // load base
    emit(enc_i(opc_op_imm, 5'd11, 3'b000, 5'd0, 12'h200));  // result base
    load_const(5'd1, rand_bits(32) | 32'h8000_0000);        // negative
    load_const(5'd2, rand_bits(32) & 32'h7fff_ffff);        // positive
    for (int k = 0; k < 6; k++) begin
      emit(enc_b(br_f3[k], 5'd1, 5'd2, 13'd8));
      emit(enc_i(opc_op_imm, 5'd5, 3'b000, 5'd5, 12'd1));
      emit(enc_b(br_f3[k], 5'd2, 5'd1, 13'd8));
      emit(enc_i(opc_op_imm, 5'd5, 3'b000, 5'd5, 12'd2));
      emit(enc_b(br_f3[k], 5'd1, 5'd1, 13'd8));
      emit(enc_i(opc_op_imm, 5'd5, 3'b000, 5'd5, 12'd4));
    end
    store_result(5'd5);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd6));
      store_result(5'd6);
      if (f == 1 || f == 5) begin
        emit(enc_i(opc_op_imm, 5'd6, 3'(f), 5'd1,
                   {(f == 5) ? 7'h20 : 7'h00, 5'(rand_bits(5))}));
        store_result(5'd6);
        if (f == 5) emit(enc_i(opc_op_imm, 5'd6, 3'd5, 5'd1, {7'h00, 5'(rand_bits(5))}));
      end else begin
        emit(enc_i(opc_op_imm, 5'd6, 3'(f), 5'd1, 12'(rand_bits(12))));
      end
      store_result(5'd6);
    end
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd6));  // sub
    store_result(5'd6);
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd6));  // sra
    store_result(5'd6);
    emit(enc_u(opc_lui, 5'd7, rand_bits(32)));
    store_result(5'd7);
    emit(enc_u(opc_auipc, 5'd7, rand_bits(32)));
    store_result(5'd7);
    for (int o = 0; o < 4; o++) emit(enc_s(3'b000, 5'd11, 5'd1, 12'(out_off + o)));
    emit(enc_s(3'b001, 5'd11, 5'd2, 12'(out_off + 4)));
    emit(enc_s(3'b001, 5'd11, 5'd2, 12'(out_off + 6)));
    out_off += 8;
    for (int o = 0; o < 4; o++) begin
      emit(enc_i(opc_load, 5'd13, 3'b000, 5'd10, 12'(o)));  // lb
      store_result(5'd13);
      emit(enc_i(opc_load, 5'd13, 3'b100, 5'd10, 12'(o)));  // lbu
      store_result(5'd13);
    end
    for (int o = 0; o < 4; o += 2) begin
      emit(enc_i(opc_load, 5'd13, 3'b001, 5'd10, 12'(o)));  // lh
      store_result(5'd13);
      emit(enc_i(opc_load, 5'd13, 3'b101, 5'd10, 12'(o)));  // lhu
      store_result(5'd13);
    end
    emit(enc_i(opc_load, 5'd13, 3'b010, 5'd10, 12'd4));
    store_result(5'd13);
    emit(enc_i(opc_op_imm, 5'd0, 3'b000, 5'd0, 12'd123));  // x0 must stay zero
    store_result(5'd0);
    emit(enc_j(5'd8, 21'd8));
    emit(enc_i(opc_op_imm, 5'd8, 3'b000, 5'd0, 12'd1));
    store_result(5'd8);
    emit(enc_u(opc_auipc, 5'd9, 32'h0));
    emit(enc_i(opc_jalr, 5'd12, 3'b000, 5'd9, 12'd13));  // odd target
    emit(enc_i(opc_op_imm, 5'd12, 3'b000, 5'd0, 12'd1));
    store_result(5'd12);
    emit(32'h0000_0000);  // unknown opcode
  endtask

  // executes the instruction at m_pc and records what the DUT must show
  task automatic model_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] w;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [3:0]  mask;
    logic [2:0]  f3;
    logic        wr;
    ins = imem[m_pc[9:2]];
    f3  = ins[14:12];
    a   = m_regs[ins[19:15]];
    b   = m_regs[ins[24:20]];
    nxt = m_pc + 4;
    wr  = 1'b0;
    res = '0;
    exp_pc  = m_pc;
    exp_wen = '0;
    case (ins[6:0])
      opc_lui: begin res = {ins[31:12], 12'h0}; wr = 1'b1; end
      opc_auipc: begin res = m_pc + {ins[31:12], 12'h0}; wr = 1'b1; end
      opc_jal: begin
        res = m_pc + 4;
        wr  = 1'b1;
        nxt = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      opc_jalr: begin
        res = m_pc + 4;
        wr  = 1'b1;
        nxt = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
      end
      opc_branch: begin
        if (branch_cond(f3, a, b))
          nxt = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      opc_load: begin
        ea = a + {{20{ins[31]}}, ins[31:20]};
        w  = m_mem[ea[9:2]] >> (8 * ea[1:0]);
        wr = 1'b1;
        case (f3)
          3'b000:  res = {{24{w[7]}}, w[7:0]};
          3'b001:  res = {{16{w[15]}}, w[15:0]};
          3'b100:  res = {24'h0, w[7:0]};
          3'b101:  res = {16'h0, w[15:0]};
          default: res = w;
        endcase
      end
      opc_store: begin
        ea   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mask = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
        exp_wen   = mask << ea[1:0];
        exp_addr  = {ea[31:2], 2'b00};
        exp_wdata = b << (8 * ea[1:0]);
        for (int k = 0; k < 4; k++) begin
          if (exp_wen[k]) m_mem[ea[9:2]][8*k +: 8] = exp_wdata[8*k +: 8];
        end
      end
      opc_op_imm: begin
        res = alu_calc(f3, a, {{20{ins[31]}}, ins[31:20]}, (f3 == 3'd5) && ins[30]);
        wr  = 1'b1;
      end
      opc_op: begin
        res = alu_calc(f3, a, b, ins[30]);
        wr  = 1'b1;
      end
      default: begin
        nxt    = m_pc;
        halted = 1'b1;
      end
    endcase
    if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
    m_pc = nxt;
  endtask

  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (instr_addr == `RV_RESET_PC && data_wenable == 4'b0000))
    else begin
      misc_errors++;
      $display("FAILED at %0t: reset state wrong, pc %h wen %b", $time, instr_addr,
               data_wenable);
    end

  pc_match: assert property (@(posedge clk) disable iff (!rst_n) instr_addr == exp_pc)
    else begin
      pc_errors++;
      $display("FAILED at %0t: pc %h, expected %h", $time, instr_addr, exp_pc);
    end

  wen_match: assert property (@(posedge clk) disable iff (!rst_n) data_wenable == exp_wen)
    else begin
      mem_errors++;
      $display("FAILED at %0t: wenable %b, expected %b", $time, data_wenable, exp_wen);
    end

  store_match: assert property (@(posedge clk) disable iff (!rst_n)
    exp_wen != 4'b0000 |-> (data_addr == exp_addr && data_wdata == exp_wdata))
    else begin
      mem_errors++;
      $display("FAILED at %0t: store %h <= %h, expected %h <= %h", $time, data_addr,
               data_wdata, exp_addr, exp_wdata);
    end

  halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> (data_wenable == 4'b0000 && $stable(instr_addr)))
    else begin
      misc_errors++;
      $display("FAILED at %0t: core moved after break, pc %h", $time, instr_addr);
    end

  initial begin
    wait (prog_ready);
    #((prog_len + 3 + 40) * 8);
    $display("watchdog expired before the run finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    prog_ready  = 1'b0;
    rst_n       = 1'b0;
    lfsr        = 32'h2a62_706b;
    prog_len    = 0;
    out_off     = 0;
    pc_errors   = 0;
    mem_errors  = 0;
    misc_errors = 0;
    halted      = 1'b0;
    m_pc        = `RV_RESET_PC;
    exp_pc      = `RV_RESET_PC;
    exp_wen     = '0;
    exp_addr    = '0;
    exp_wdata   = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i]  = 32'h0000_0000;
      dmem[i]  = {i[7:0], ~i[7:0], i[7:0] ^ 8'ha5, i[7:0] + 8'h3c};
      m_mem[i] = dmem[i];
    end
    for (int r = 0; r < 32; r++) m_regs[r] = '0;
    build_program();
    prog_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    model_step();
    repeat (prog_len + 8) begin
      @(posedge clk);
      #1 model_step();
    end
    if (!halted) begin
      misc_errors++;
      $display("the program never reached its final break");
    end
    $display("errors: pc %0d, memory %0d, reset/halt %0d", pc_errors, mem_errors,
             misc_errors);
    if (pc_errors + mem_errors + misc_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst_n,
  output logic [`RV_XLEN-1:0] instr_addr,
  input  logic [31:0]         instr_data,
  output logic [`RV_XLEN-1:0] data_addr,
  output logic [`RV_XLEN-1:0] data_wdata,
  output logic [3:0]          data_wenable,
  input  logic [`RV_XLEN-1:0] data_rdata
);

  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] store_data;
  logic [`RV_XLEN-1:0] pc_plus_4;
  logic [`RV_XLEN-1:0] pc_target;
  logic [`RV_XLEN-1:0] wb_data;

  rv_ctrl_if ctrl_bus ();

  rv_decoder u_decoder (
    .instr (instr_data),
    .ctrl  (ctrl_bus.dec)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl_bus.exe),
    .wb_data    (wb_data),
    .pc         (instr_addr),  // registered pc drives fetch
    .alu_result (alu_result),
    .store_data (store_data),
    .pc_plus_4  (pc_plus_4),
    .pc_target  (pc_target)
  );

  rv_mem_stage u_mem_stage (
    .rst_n        (rst_n),
    .ctrl         (ctrl_bus.mem),
    .alu_result   (alu_result),
    .store_data   (store_data),
    .pc_plus_4    (pc_plus_4),
    .pc_target    (pc_target),
    .data_rdata   (data_rdata),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_wenable (data_wenable),
    .wb_data      (wb_data)
  );

endmodule

// ==== design/rv_mem_stage.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_mem_stage (
  input  logic                rst_n,
  rv_ctrl_if.mem              ctrl,
  input  logic [`RV_XLEN-1:0] alu_result,
  input  logic [`RV_XLEN-1:0] store_data,
  input  logic [`RV_XLEN-1:0] pc_plus_4,
  input  logic [`RV_XLEN-1:0] pc_target,
  input  logic [`RV_XLEN-1:0] data_rdata,
  output logic [`RV_XLEN-1:0] data_addr,
  output logic [`RV_XLEN-1:0] data_wdata,
  output logic [3:0]          data_wenable,
  output logic [`RV_XLEN-1:0] wb_data
);
  import rv_ctrl_pkg::*;

  logic [1:0]          byte_off;
  logic [`RV_XLEN-1:0] lane;  // addressed bytes moved to bit 0
  logic [`RV_XLEN-1:0] load_data;
  logic                is_access;

  assign byte_off  = alu_result[1:0];
  assign data_addr = {alu_result[`RV_XLEN-1:2], 2'b00};

  assign data_wdata   = store_data << {byte_off, 3'b000};
  assign data_wenable = rst_n ? (ctrl.mem_write << byte_off) : 4'b0000;

  assign lane = data_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};    // lb
      3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};  // lh
      3'b100:  load_data = {24'h000000, lane[7:0]};       // lbu
      3'b101:  load_data = {16'h0000, lane[15:0]};        // lhu
      default: load_data = lane;                          // lw
    endcase
  end

  always_comb begin
    case (ctrl.result_src)
      res_alu:       wb_data = alu_result;
      res_data:      wb_data = load_data;
      res_pc_target: wb_data = pc_target;
      res_pc_step:   wb_data = pc_plus_4;
      default:       wb_data = alu_result;
    endcase
  end

  assign is_access = rst_n && ((ctrl.result_src == res_data) || (ctrl.mem_write != 4'b0000));

  // address from execute must suit the width from the decoder
  always_comb begin
    if (is_access) begin
      half_aligned: assert final (!(ctrl.funct3[1:0] == 2'b01 && byte_off[0]))
        else $error("half-word access at odd address %h", alu_result);
      word_aligned: assert final (!(ctrl.funct3[1:0] == 2'b10 && byte_off != 2'b00))
        else $error("word access not aligned %h", alu_result);
    end
  end

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_execute (
  input  logic                clk,
  input  logic                rst_n,
  rv_ctrl_if.exe              ctrl,
  input  logic [`RV_XLEN-1:0] wb_data,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] store_data,
  output logic [`RV_XLEN-1:0] pc_plus_4,
  output logic [`RV_XLEN-1:0] pc_target
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [`RV_XLEN-1:0] regs [`RV_REGS];
  logic [`RV_XLEN-1:0] rd1;
  logic [`RV_XLEN-1:0] rd2;
  logic [`RV_XLEN-1:0] src_b;
  logic [`RV_XLEN:0]   diff;  // extra bit holds the borrow
  logic [4:0]          shamt;
  logic                alu_zero;
  logic                alu_lt;
  logic                alu_borrow;
  logic                taken;
  logic [`RV_XLEN-1:0] pc_next;

  // x0 is never written, so it reads zero
  assign rd1 = regs[ctrl.rs1];
  assign rd2 = regs[ctrl.rs2];

  assign store_data = rd2;
  assign src_b      = (ctrl.alu_src_b == src_b_imm) ? ctrl.imm : rd2;
  assign shamt      = src_b[4:0];

  assign diff       = {1'b0, rd1} - {1'b0, src_b};
  assign alu_borrow = diff[`RV_XLEN];
  assign alu_zero   = (diff[`RV_XLEN-1:0] == '0);
  // on a sign mismatch rs1 negative means less
  assign alu_lt     = (rd1[`RV_XLEN-1] != src_b[`RV_XLEN-1]) ? rd1[`RV_XLEN-1]
                                                             : diff[`RV_XLEN-1];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_result = rd1 + src_b;
      alu_sub:    alu_result = diff[`RV_XLEN-1:0];
      alu_sll:    alu_result = rd1 << shamt;
      alu_slt:    alu_result = {{(`RV_XLEN-1){1'b0}}, alu_lt};
      alu_sltu:   alu_result = {{(`RV_XLEN-1){1'b0}}, alu_borrow};
      alu_xor:    alu_result = rd1 ^ src_b;
      alu_srl:    alu_result = rd1 >> shamt;
      alu_sra:    alu_result = $signed(rd1) >>> shamt;
      alu_or:     alu_result = rd1 | src_b;
      alu_and:    alu_result = rd1 & src_b;
      alu_pass_b: alu_result = src_b;
      default:    alu_result = '0;
    endcase
  end

  assign pc_plus_4 = pc + `RV_XLEN'd4;
  assign pc_target = pc + ctrl.imm;

  always_comb begin
    case (ctrl.funct3)
      3'b000:  taken = alu_zero;     // beq
      3'b001:  taken = !alu_zero;    // bne
      3'b100:  taken = alu_lt;       // blt
      3'b101:  taken = !alu_lt;      // bge
      3'b110:  taken = alu_borrow;   // bltu
      3'b111:  taken = !alu_borrow;  // bgeu
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.branch_type)
      br_none:  pc_next = pc_plus_4;
      br_cond:  pc_next = taken ? pc_target : pc_plus_4;
      br_jal:   pc_next = pc_target;
      br_jalr:  pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
      br_break: pc_next = pc;
      default:  pc_next = pc_plus_4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write && (ctrl.rd != '0)) begin
      regs[ctrl.rd] <= wb_data;
    end
  end

  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0] instr,
  rv_ctrl_if.dec      ctrl
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  rv_opcode_e opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  logic       alt_ok;  // sub/sra select allowed
  imm_src_e   imm_src;

  assign opcode   = rv_opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign ctrl.funct3 = funct3;
  assign ctrl.rs1    = instr[19:15];
  assign ctrl.rs2    = instr[24:20];
  assign ctrl.rd     = instr[11:7];

  // register form may pick sub or sra, the others ignore funct7
  assign alt_ok = (funct3 == 3'b000) || (funct3 == 3'b101);

  always_comb begin
    ctrl.branch_type = br_none;
    ctrl.result_src  = res_alu;
    ctrl.alu_op      = alu_add;
    ctrl.alu_src_b   = src_b_rd2;
    ctrl.reg_write   = 1'b0;
    ctrl.mem_write   = 4'b0000;
    imm_src          = imm_i;

    case (opcode)
      opc_load: begin
        ctrl.alu_src_b  = src_b_imm;
        ctrl.result_src = res_data;
        ctrl.reg_write  = 1'b1;
      end
      opc_op_imm: begin
        ctrl.alu_src_b = src_b_imm;
        ctrl.alu_op    = rv_alu_op_e'({(funct3 == 3'b101) ? funct7_5 : 1'b0, funct3});  // srai only
        ctrl.reg_write = 1'b1;
      end
      opc_auipc: begin
        imm_src         = imm_u;
        ctrl.result_src = res_pc_target;
        ctrl.reg_write  = 1'b1;
      end
      opc_store: begin
        imm_src        = imm_s;
        ctrl.alu_src_b = src_b_imm;
        case (funct3)
          3'b000:  ctrl.mem_write = 4'b0001;
          3'b001:  ctrl.mem_write = 4'b0011;
          3'b010:  ctrl.mem_write = 4'b1111;
          default: ctrl.branch_type = br_break;  // no such store width
        endcase
      end
      opc_op: begin
        ctrl.alu_op    = rv_alu_op_e'({alt_ok ? funct7_5 : 1'b0, funct3});
        ctrl.reg_write = 1'b1;
      end
      opc_lui: begin
        imm_src        = imm_u;
        ctrl.alu_src_b = src_b_imm;
        ctrl.alu_op    = alu_pass_b;
        ctrl.reg_write = 1'b1;
      end
      opc_branch: begin
        imm_src          = imm_b;
        ctrl.alu_op      = alu_sub;  // flags come from rs1 - rs2
        ctrl.branch_type = br_cond;
      end
      opc_jalr: begin
        ctrl.alu_src_b   = src_b_imm;
        ctrl.branch_type = br_jalr;
        ctrl.result_src  = res_pc_step;
        ctrl.reg_write   = 1'b1;
      end
      opc_jal: begin
        imm_src          = imm_j;
        ctrl.branch_type = br_jal;
        ctrl.result_src  = res_pc_step;
        ctrl.reg_write   = 1'b1;
      end
      default: begin
        ctrl.branch_type = br_break;
      end
    endcase

    case (imm_src)
      imm_i:   ctrl.imm = {{20{instr[31]}}, instr[31:20]};
      imm_s:   ctrl.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b:   ctrl.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u:   ctrl.imm = {instr[31:12], 12'h000};
      imm_j:   ctrl.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: ctrl.imm = '0;
    endcase
  end

endmodule

// ==== design/rv_ctrl_if.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

interface rv_ctrl_if;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  branch_type_e                       branch_type;
  result_src_e                        result_src;
  rv_alu_op_e                         alu_op;
  alu_src_b_e                         alu_src_b;
  logic                               reg_write;
  logic [3:0]                         mem_write;  // byte mask, not yet lane shifted
  logic [2:0]                         funct3;
  logic [`RV_XLEN-1:0]                imm;
  logic [$clog2(`RV_REGS)-1:0]        rs1;
  logic [$clog2(`RV_REGS)-1:0]        rs2;
  logic [$clog2(`RV_REGS)-1:0]        rd;

  modport dec (output branch_type, result_src, alu_op, alu_src_b, reg_write,
               output mem_write, funct3, imm, rs1, rs2, rd);

  modport exe (input branch_type, alu_op, alu_src_b, reg_write, funct3, imm,
               input rs1, rs2, rd);

  modport mem (input result_src, mem_write, funct3);

endinterface

// ==== design/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

  // how the next pc is chosen
  typedef enum logic [2:0] {
    br_none  = 3'd0,
    br_cond  = 3'd1,
    br_jal   = 3'd2,
    br_jalr  = 3'd3,
    br_break = 3'd4  // pc holds, no writes
  } branch_type_e;

  // write-back source
  typedef enum logic [1:0] {
    res_alu       = 2'd0,
    res_data      = 2'd1,
    res_pc_target = 2'd2,
    res_pc_step   = 2'd3
  } result_src_e;

  typedef enum logic {
    src_b_rd2 = 1'b0,
    src_b_imm = 1'b1
  } alu_src_b_e;

  // immediate formats
  typedef enum logic [2:0] {
    imm_i = 3'd0,
    imm_s = 3'd1,
    imm_b = 3'd2,
    imm_u = 3'd3,
    imm_j = 3'd4
  } imm_src_e;

endpackage

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes of the base integer set
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } rv_opcode_e;

  // packed as {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_sra    = 4'b1101,
    alu_pass_b = 4'b1111  // lui
  } rv_alu_op_e;

endpackage

// ==== design/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define RV_XLEN 32

// architectural registers
`define RV_REGS 32

`define RV_RESET_PC 32'h0000_0000

`endif
